/* rtl/exu_pkg.sv */
package exu_pkg;

    parameter int XLEN = 32;

    // Major opcodes handled by the execute unit
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [4:0] {
        UOP_NOP,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLL,
        UOP_SLT,
        UOP_SLTU,
        UOP_PACK,
        UOP_REV,
        UOP_SH1ADD,
        UOP_CTZ,     // Stepped
        UOP_CPOP,    // Stepped
        UOP_HMDST    // Stepped
    } uop_e;

    typedef enum logic [2:0] {
        BRC_NONE,
        BRC_EQ,
        BRC_NE,
        BRC_LT,
        BRC_GE,
        BRC_LTU,
        BRC_GEU
    } brc_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        uop_e            uop;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
    } alu_req_t;

    typedef struct packed {
        logic eq;
        logic lt;   // Signed
        logic ltu;
    } alu_flags_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_t;

endpackage

/* rtl/exu_decoder.sv */
`timescale 1ns/1ps

module exu_decoder (
    input  exu_pkg::instr_u          instr_i,
    input  logic                     valid_i,
    input  logic [exu_pkg::XLEN-1:0] rs1_val_i,
    input  logic [exu_pkg::XLEN-1:0] rs2_val_i,
    output exu_pkg::alu_req_t        req_o,
    output logic [4:0]               rd_o,
    output exu_pkg::brc_e            brc_o,
    output logic [exu_pkg::XLEN-1:0] imm_o,
    output logic                     illegal_o
);

    exu_pkg::uop_e            uop;
    exu_pkg::brc_e            brc;
    logic                     use_imm;
    logic                     legal;
    logic [exu_pkg::XLEN-1:0] imm_i_ext;
    logic [exu_pkg::XLEN-1:0] imm_b_ext;

    assign imm_i_ext = {{(exu_pkg::XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    // B-type offset sits in the funct7 and rd slots
    assign imm_b_ext = {{(exu_pkg::XLEN-13){instr_i.r.funct7[6]}}, instr_i.r.funct7[6],
                        instr_i.r.rd[0], instr_i.r.funct7[5:0], instr_i.r.rd[4:1], 1'b0};

    always_comb begin
        uop     = exu_pkg::UOP_NOP;
        brc     = exu_pkg::BRC_NONE;
        use_imm = 1'b0;
        legal   = 1'b1;
        case (instr_i.r.opcode)
        exu_pkg::OPC_OP: begin
            case ({instr_i.r.funct7, instr_i.r.funct3})
            {7'b0000000, 3'b000}: uop = exu_pkg::UOP_ADD;
            {7'b0000000, 3'b001}: uop = exu_pkg::UOP_SLL;
            {7'b0000000, 3'b010}: uop = exu_pkg::UOP_SLT;
            {7'b0000000, 3'b011}: uop = exu_pkg::UOP_SLTU;
            {7'b0000000, 3'b100}: uop = exu_pkg::UOP_XOR;
            {7'b0000000, 3'b110}: uop = exu_pkg::UOP_OR;
            {7'b0000000, 3'b111}: uop = exu_pkg::UOP_AND;
            {7'b0100000, 3'b000}: uop = exu_pkg::UOP_SUB;
            {7'b0000100, 3'b100}: uop = exu_pkg::UOP_PACK;
            {7'b0010000, 3'b010}: uop = exu_pkg::UOP_SH1ADD;
            {7'b0000101, 3'b001}: uop = exu_pkg::UOP_HMDST;
            default:              legal = 1'b0;
            endcase
        end
        exu_pkg::OPC_OP_IMM: begin
            use_imm = 1'b1;
            case (instr_i.i.funct3)
            3'b000: uop = exu_pkg::UOP_ADD;
            3'b010: uop = exu_pkg::UOP_SLT;
            3'b011: uop = exu_pkg::UOP_SLTU;
            3'b100: uop = exu_pkg::UOP_XOR;
            3'b110: uop = exu_pkg::UOP_OR;
            3'b111: uop = exu_pkg::UOP_AND;
            3'b001: begin
                if (instr_i.r.funct7 == 7'b0000000) begin
                    uop = exu_pkg::UOP_SLL;   // shamt is the low imm bits
                end else if (instr_i.r.funct7 == 7'b0110000) begin
                    case (instr_i.r.rs2)  // Unary ops select on rs2 slot
                    5'b00001: uop = exu_pkg::UOP_CTZ;
                    5'b00010: uop = exu_pkg::UOP_CPOP;
                    5'b00011: uop = exu_pkg::UOP_REV;
                    default:  legal = 1'b0;
                    endcase
                end else begin
                    legal = 1'b0;
                end
            end
            default: legal = 1'b0;
            endcase
        end
        exu_pkg::OPC_BRANCH: begin
            uop = exu_pkg::UOP_SUB;  // Only the flags matter
            case (instr_i.r.funct3)
            3'b000:  brc = exu_pkg::BRC_EQ;
            3'b001:  brc = exu_pkg::BRC_NE;
            3'b100:  brc = exu_pkg::BRC_LT;
            3'b101:  brc = exu_pkg::BRC_GE;
            3'b110:  brc = exu_pkg::BRC_LTU;
            3'b111:  brc = exu_pkg::BRC_GEU;
            default: legal = 1'b0;
            endcase
        end
        default: legal = 1'b0;
        endcase
    end

    assign req_o.uop  = (valid_i && legal) ? uop : exu_pkg::UOP_NOP;
    assign req_o.op_a = rs1_val_i;
    assign req_o.op_b = use_imm ? imm_i_ext : rs2_val_i;
    assign rd_o       = instr_i.r.rd;
    assign brc_o      = (valid_i && legal) ? brc : exu_pkg::BRC_NONE;
    assign imm_o      = (brc != exu_pkg::BRC_NONE) ? imm_b_ext : imm_i_ext;
    assign illegal_o  = valid_i & ~legal;

endmodule

/* rtl/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu #(
    parameter int STEP_BITS = 8
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  exu_pkg::alu_req_t        req_i,
    output logic [exu_pkg::XLEN-1:0] result_o,
    output exu_pkg::alu_flags_t      flags_o,
    output logic                     done_o
);

    localparam int NSTEPS   = exu_pkg::XLEN / STEP_BITS;
    localparam int CNT_BITS = $clog2(NSTEPS + 1);
    localparam int SH_BITS  = $clog2(exu_pkg::XLEN);
    localparam int HALF     = exu_pkg::XLEN / 2;

    logic [CNT_BITS-1:0]      step_q;
    logic [exu_pkg::XLEN-1:0] acc_q;
    logic                     ctz_hit_q;     // A one was seen in an earlier step
    logic                     stepped;
    logic                     last_step;
    logic [exu_pkg::XLEN-1:0] step_src;
    logic [STEP_BITS-1:0]     step_bits;
    logic [exu_pkg::XLEN-1:0] step_sum;
    logic                     ctz_run;

    assign stepped = (req_i.uop == exu_pkg::UOP_CTZ) ||
                     (req_i.uop == exu_pkg::UOP_CPOP) ||
                     (req_i.uop == exu_pkg::UOP_HMDST);
    assign last_step = (step_q == CNT_BITS'(NSTEPS));
    assign done_o    = ~stepped | last_step;

    assign flags_o.eq  = req_i.op_a == req_i.op_b;
    assign flags_o.lt  = $signed(req_i.op_a) < $signed(req_i.op_b);
    assign flags_o.ltu = req_i.op_a < req_i.op_b;

    // HMDST counts ones of the difference
    assign step_src  = (req_i.uop == exu_pkg::UOP_HMDST) ? (req_i.op_a ^ req_i.op_b)
                                                         : req_i.op_a;
    assign step_bits = STEP_BITS'(step_src >> (int'(step_q) * STEP_BITS));

    always_comb begin
        step_sum = '0;
        ctz_run  = ~ctz_hit_q;
        for (int i = 0; i < STEP_BITS; i++) begin
            if (req_i.uop != exu_pkg::UOP_CTZ) begin
                step_sum = step_sum + exu_pkg::XLEN'(step_bits[i]);
            end else if (step_bits[i]) begin
                ctz_run = 1'b0;  // Stop at first set bit
            end else if (ctz_run) begin
                step_sum = step_sum + 1'b1;
            end
        end
    end

    always_comb begin
        result_o = '0;
        case (req_i.uop)
        exu_pkg::UOP_ADD:  result_o = req_i.op_a + req_i.op_b;
        exu_pkg::UOP_SUB:  result_o = req_i.op_a - req_i.op_b;
        exu_pkg::UOP_AND:  result_o = req_i.op_a & req_i.op_b;
        exu_pkg::UOP_OR:   result_o = req_i.op_a | req_i.op_b;
        exu_pkg::UOP_XOR:  result_o = req_i.op_a ^ req_i.op_b;
        exu_pkg::UOP_SLL:  result_o = req_i.op_a << req_i.op_b[SH_BITS-1:0];
        exu_pkg::UOP_SLT:  result_o = exu_pkg::XLEN'(flags_o.lt);
        exu_pkg::UOP_SLTU: result_o = exu_pkg::XLEN'(flags_o.ltu);
        exu_pkg::UOP_PACK: begin
            result_o = {req_i.op_b[HALF +: HALF], req_i.op_a[0 +: HALF]};
        end
        exu_pkg::UOP_REV: begin
            for (int i = 0; i < exu_pkg::XLEN; i++) begin
                result_o[i] = req_i.op_a[exu_pkg::XLEN-1-i];
            end
        end
        exu_pkg::UOP_SH1ADD: begin
            result_o = {req_i.op_a[exu_pkg::XLEN-2:0], 1'b0} + req_i.op_b;
        end
        exu_pkg::UOP_CTZ,
        exu_pkg::UOP_CPOP,
        exu_pkg::UOP_HMDST: result_o = acc_q;  // Final on the done cycle
        default:            result_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            step_q    <= '0;
            acc_q     <= '0;
            ctz_hit_q <= 1'b0;
        end else if (done_o) begin
            step_q    <= '0;
            acc_q     <= '0;
            ctz_hit_q <= 1'b0;
        end else begin
            step_q    <= step_q + 1'b1;
            acc_q     <= acc_q + step_sum;
            ctz_hit_q <= ctz_hit_q | (|step_bits);
        end
    end

    // Core must hold the op until the count is out
    a_uop_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        stepped && !done_o |=> req_i.uop == $past(req_i.uop))
        else $error("ALU micro-op changed during a stepped operation");

    a_step_divides: assert property (@(posedge clk_i)
        (exu_pkg::XLEN % STEP_BITS) == 0)
        else $error("XLEN is not a multiple of STEP_BITS");

    a_step_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        step_q <= CNT_BITS'(NSTEPS))
        else $error("Step counter ran past the last step");

endmodule

/* rtl/exu_resolve.sv */
`timescale 1ns/1ps

module exu_resolve (
    input  logic                     req_valid_i,
    input  logic [4:0]               rd_i,
    input  exu_pkg::brc_e            brc_i,
    input  logic [exu_pkg::XLEN-1:0] imm_i,
    input  logic [exu_pkg::XLEN-1:0] pc_i,
    input  logic [exu_pkg::XLEN-1:0] result_i,
    input  exu_pkg::alu_flags_t      flags_i,
    input  logic                     done_i,
    output exu_pkg::wb_t             wb_o,
    output logic                     wb_valid_o,
    output exu_pkg::br_t             br_o,
    output logic                     br_valid_o,
    output logic                     busy_o
);

    logic is_branch;
    logic taken;

    assign is_branch = brc_i != exu_pkg::BRC_NONE;

    always_comb begin
        case (brc_i)
        exu_pkg::BRC_EQ:  taken = flags_i.eq;
        exu_pkg::BRC_NE:  taken = ~flags_i.eq;
        exu_pkg::BRC_LT:  taken = flags_i.lt;
        exu_pkg::BRC_GE:  taken = ~flags_i.lt;
        exu_pkg::BRC_LTU: taken = flags_i.ltu;
        exu_pkg::BRC_GEU: taken = ~flags_i.ltu;
        default:          taken = 1'b0;
        endcase
    end

    assign wb_o.rd    = rd_i;
    assign wb_o.data  = result_i;
    assign wb_valid_o = req_valid_i & done_i & ~is_branch;

    assign br_o.taken  = taken;
    assign br_o.target = pc_i + imm_i;  // Target even when not taken
    assign br_valid_o  = req_valid_i & done_i & is_branch;

    assign busy_o = req_valid_i & ~done_i;

    always_comb begin
        a_one_result: assert (!(wb_valid_o && br_valid_o))
            else $error("Writeback and branch issued together");
    end

endmodule

/* rtl/exu_top.sv */
`timescale 1ns/1ps

module exu_top #(
    parameter int STEP_BITS = 8
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  exu_pkg::instr_u          instr_i,
    input  logic                     valid_i,
    input  logic [exu_pkg::XLEN-1:0] pc_i,
    input  logic [exu_pkg::XLEN-1:0] rs1_val_i,
    input  logic [exu_pkg::XLEN-1:0] rs2_val_i,
    output exu_pkg::wb_t             wb_o,
    output logic                     wb_valid_o,
    output exu_pkg::br_t             br_o,
    output logic                     br_valid_o,
    output logic                     busy_o,
    output logic                     illegal_o
);

    exu_pkg::alu_req_t        alu_req;
    exu_pkg::alu_flags_t      alu_flags;
    exu_pkg::brc_e            dec_brc;
    logic [4:0]               dec_rd;
    logic [exu_pkg::XLEN-1:0] dec_imm;
    logic [exu_pkg::XLEN-1:0] alu_result;
    logic                     alu_done;
    logic                     req_valid;

    assign req_valid = valid_i & ~illegal_o;  // Illegal words produce nothing

    exu_decoder u_decoder (
        .instr_i   (instr_i),
        .valid_i   (valid_i),
        .rs1_val_i (rs1_val_i),
        .rs2_val_i (rs2_val_i),
        .req_o     (alu_req),
        .rd_o      (dec_rd),
        .brc_o     (dec_brc),
        .imm_o     (dec_imm),
        .illegal_o (illegal_o)
    );

    exu_alu #(
        .STEP_BITS (STEP_BITS)
    ) u_alu (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .req_i    (alu_req),
        .result_o (alu_result),
        .flags_o  (alu_flags),
        .done_o   (alu_done)
    );

    exu_resolve u_resolve (
        .req_valid_i (req_valid),
        .rd_i        (dec_rd),
        .brc_i       (dec_brc),
        .imm_i       (dec_imm),
        .pc_i        (pc_i),
        .result_i    (alu_result),
        .flags_i     (alu_flags),
        .done_i      (alu_done),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o),
        .br_o        (br_o),
        .br_valid_o  (br_valid_o),
        .busy_o      (busy_o)
    );

endmodule

/* tb/tb_exu.sv */
`timescale 1ns/1ps

module tb_exu;

    localparam int XLEN      = exu_pkg::XLEN;
    localparam int STEP_BITS = 8;
    localparam int MAX_WAIT  = 20;

    logic                clk_i;
    logic                rstn_i;
    exu_pkg::instr_u     instr_i;
    logic                valid_i;
    logic [XLEN-1:0]     pc_i;
    logic [XLEN-1:0]     rs1_val_i;
    logic [XLEN-1:0]     rs2_val_i;
    exu_pkg::wb_t        wb_o;
    logic                wb_valid_o;
    exu_pkg::br_t        br_o;
    logic                br_valid_o;
    logic                busy_o;
    logic                illegal_o;

    int     errors;
    int     tests_failed;
    int     tests_run;
    integer seed;

    exu_top #(
        .STEP_BITS (STEP_BITS)
    ) dut_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .instr_i    (instr_i),
        .valid_i    (valid_i),
        .pc_i       (pc_i),
        .rs1_val_i  (rs1_val_i),
        .rs2_val_i  (rs2_val_i),
        .wb_o       (wb_o),
        .wb_valid_o (wb_valid_o),
        .br_o       (br_o),
        .br_valid_o (br_valid_o),
        .busy_o     (busy_o),
        .illegal_o  (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic exu_pkg::instr_u encode_r(input logic [6:0] f7, input logic [4:0] f5,
            input logic [2:0] f3, input logic [6:0] opc, input logic [4:0] rd);
        exu_pkg::instr_u ins;
        ins.r.funct7 = f7;
        ins.r.rs2    = f5;
        ins.r.rs1    = 5'd1;
        ins.r.funct3 = f3;
        ins.r.rd     = rd;
        ins.r.opcode = opc;
        return ins;
    endfunction

    function automatic exu_pkg::instr_u encode_i(input logic [11:0] imm, input logic [2:0] f3,
            input logic [4:0] rd);
        exu_pkg::instr_u ins;
        ins.i.imm12  = imm;
        ins.i.rs1    = 5'd1;
        ins.i.funct3 = f3;
        ins.i.rd     = rd;
        ins.i.opcode = exu_pkg::OPC_OP_IMM;
        return ins;
    endfunction

    // Standard B-format scatter of a 13-bit offset
    function automatic exu_pkg::instr_u encode_b(input logic [12:0] off, input logic [2:0] f3);
        exu_pkg::instr_u ins;
        ins = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], exu_pkg::OPC_BRANCH};
        return ins;
    endfunction

    function automatic logic [31:0] count_ones(input logic [31:0] x);
        logic [31:0] n;
        n = '0;
        for (int j = 0; j < XLEN; j++) begin
            n = n + 32'(x[j]);
        end
        return n;
    endfunction

    function automatic logic [31:0] trailing_zeros(input logic [31:0] x);
        logic [31:0] n;
        n = XLEN;  // No set bit at all
        for (int j = XLEN - 1; j >= 0; j--) begin
            if (x[j]) n = j;
        end
        return n;
    endfunction

    function automatic logic [31:0] reverse_bits(input logic [31:0] x);
        logic [31:0] r;
        for (int j = 0; j < XLEN; j++) begin
            r[XLEN-1-j] = x[j];
        end
        return r;
    endfunction

    // Reference model with kind 0 for writeback, 1 for branch and 2 for illegal
    function automatic void model(input exu_pkg::instr_u ins, input logic [31:0] a,
            input logic [31:0] b, input logic [31:0] pc, output int kind,
            output exu_pkg::wb_t wb, output exu_pkg::br_t br, output int busy);
        logic [31:0] word;
        logic [31:0] imm;
        logic [31:0] res;
        logic [6:0]  f7;
        logic [4:0]  f5;
        logic [2:0]  f3;
        word = ins;
        f7   = word[31:25];
        f5   = word[24:20];
        f3   = word[14:12];
        imm  = {{20{word[31]}}, word[31:20]};
        kind = 0;
        busy = 0;
        res  = '0;
        br   = '0;
        if (word[6:0] == exu_pkg::OPC_OP) begin
            case ({f7, f3})
            10'b0000000_000: res = a + b;
            10'b0000000_001: res = a << b[4:0];
            10'b0000000_010: res = 32'($signed(a) < $signed(b));
            10'b0000000_011: res = 32'(a < b);
            10'b0000000_100: res = a ^ b;
            10'b0000000_110: res = a | b;
            10'b0000000_111: res = a & b;
            10'b0100000_000: res = a - b;
            10'b0000100_100: res = {b[31:16], a[15:0]};
            10'b0010000_010: res = (a << 1) + b;
            10'b0000101_001: begin
                res  = count_ones(a ^ b);
                busy = XLEN / STEP_BITS;
            end
            default: kind = 2;
            endcase
        end else if (word[6:0] == exu_pkg::OPC_OP_IMM) begin
            case (f3)
            3'b000: res = a + imm;
            3'b010: res = 32'($signed(a) < $signed(imm));
            3'b011: res = 32'(a < imm);
            3'b100: res = a ^ imm;
            3'b110: res = a | imm;
            3'b111: res = a & imm;
            3'b001: begin
                if (f7 == 7'b0000000) begin
                    res = a << f5;
                end else if (f7 == 7'b0110000 && f5 == 5'd1) begin
                    res  = trailing_zeros(a);
                    busy = XLEN / STEP_BITS;
                end else if (f7 == 7'b0110000 && f5 == 5'd2) begin
                    res  = count_ones(a);
                    busy = XLEN / STEP_BITS;
                end else if (f7 == 7'b0110000 && f5 == 5'd3) begin
                    res = reverse_bits(a);
                end else begin
                    kind = 2;
                end
            end
            default: kind = 2;
            endcase
        end else if (word[6:0] == exu_pkg::OPC_BRANCH) begin
            kind      = 1;
            br.target = pc + {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            case (f3)
            3'b000:  br.taken = a == b;
            3'b001:  br.taken = a != b;
            3'b100:  br.taken = $signed(a) < $signed(b);
            3'b101:  br.taken = $signed(a) >= $signed(b);
            3'b110:  br.taken = a < b;
            3'b111:  br.taken = a >= b;
            default: kind = 2;
            endcase
        end else begin
            kind = 2;
        end
        wb.rd   = word[11:7];
        wb.data = res;
    endfunction

    task automatic check_wb(input string name, input exu_pkg::wb_t exp, input exu_pkg::wb_t act);
        if (exp !== act) begin
            $display("mismatch %s: wb expected rd %0d data %h, actual rd %0d data %h",
                     name, exp.rd, exp.data, act.rd, act.data);
            errors++;
        end
    endtask

    task automatic check_br(input string name, input exu_pkg::br_t exp, input exu_pkg::br_t act);
        if (exp !== act) begin
            $display("mismatch %s: br expected taken %b target %h, actual taken %b target %h",
                     name, exp.taken, exp.target, act.taken, act.target);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
            input logic act);
        if (exp !== act) begin
            $display("mismatch %s: %s expected %b actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("mismatch %s: busy cycles expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Drive one instruction, hold it while busy, check at the done cycle
    task automatic run_instr(input string name, input exu_pkg::instr_u ins,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] pc);
        int           kind;
        int           exp_busy;
        int           busy_cnt;
        exu_pkg::wb_t exp_wb;
        exu_pkg::br_t exp_br;
        model(ins, a, b, pc, kind, exp_wb, exp_br, exp_busy);
        @(posedge clk_i);
        instr_i   <= ins;
        valid_i   <= 1'b1;
        rs1_val_i <= a;
        rs2_val_i <= b;
        pc_i      <= pc;
        busy_cnt = 0;
        @(negedge clk_i);
        while (busy_o && busy_cnt < MAX_WAIT) begin
            busy_cnt++;
            @(negedge clk_i);
        end
        if (busy_o) begin
            $display("%s: busy_o did not drop within %0d cycles", name, MAX_WAIT);
            errors++;
        end
        check_count(name, exp_busy, busy_cnt);
        check_flag(name, "illegal_o", kind == 2, illegal_o);
        check_flag(name, "wb_valid_o", kind == 0, wb_valid_o);
        check_flag(name, "br_valid_o", kind == 1, br_valid_o);
        if (kind == 0 && wb_valid_o) check_wb(name, exp_wb, wb_o);
        if (kind == 1 && br_valid_o) check_br(name, exp_br, br_o);
    endtask

    task automatic check_idle(input string name, input exu_pkg::instr_u ins);
        @(posedge clk_i);
        instr_i <= ins;
        valid_i <= 1'b0;
        @(negedge clk_i);
        check_flag(name, "wb_valid_o", 1'b0, wb_valid_o);
        check_flag(name, "br_valid_o", 1'b0, br_valid_o);
        check_flag(name, "busy_o", 1'b0, busy_o);
        check_flag(name, "illegal_o", 1'b0, illegal_o);
    endtask

    task automatic finish_test(input string test, input int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: ok", test);
        end else begin
            $display("%s: %0d errors", test, errors - start);
            tests_failed++;
        end
    endtask

    task automatic test_arith();
        int start;
        start = errors;
        run_instr("add wrap", encode_r(7'h00, 5'd2, 3'b000, exu_pkg::OPC_OP, 5'd3),
                  32'h7fff_ffff, 32'h1, '0);
        run_instr("sub wrap", encode_r(7'h20, 5'd2, 3'b000, exu_pkg::OPC_OP, 5'd4), 0, 1, '0);
        run_instr("and", encode_r(7'h00, 5'd2, 3'b111, exu_pkg::OPC_OP, 5'd5),
                  32'hf0f0_1234, 32'h0ff0_ffff, '0);
        run_instr("or", encode_r(7'h00, 5'd2, 3'b110, exu_pkg::OPC_OP, 5'd6),
                  32'hf000_0001, 32'h0f00_0010, '0);
        run_instr("xor", encode_r(7'h00, 5'd2, 3'b100, exu_pkg::OPC_OP, 5'd7),
                  32'haaaa_5555, 32'hffff_0000, '0);
        run_instr("sll masked", encode_r(7'h00, 5'd2, 3'b001, exu_pkg::OPC_OP, 5'd8),
                  32'h8000_0003, 32'h0000_0024, '0);
        run_instr("addi neg", encode_i(12'hfff, 3'b000, 5'd9), 32'h0, 32'h0, '0);
        run_instr("addi min", encode_i(12'h800, 3'b000, 5'd10), 32'h8000_0000, 32'h0, '0);
        run_instr("slli 31", encode_r(7'h00, 5'd31, 3'b001, exu_pkg::OPC_OP_IMM, 5'd11),
                  32'h0000_0003, 32'h0, '0);
        finish_test("arith", start);
    endtask

    task automatic test_compare();
        int          start;
        logic [31:0] pc;
        start = errors;
        pc    = 32'h0000_1000;
        run_instr("slt", encode_r(7'h00, 5'd2, 3'b010, exu_pkg::OPC_OP, 5'd1),
                  32'hffff_ffff, 32'h1, pc);
        run_instr("sltu", encode_r(7'h00, 5'd2, 3'b011, exu_pkg::OPC_OP, 5'd2),
                  32'hffff_ffff, 32'h1, pc);
        run_instr("slti", encode_i(12'h001, 3'b010, 5'd3), 32'h8000_0000, 32'h0, pc);
        run_instr("sltiu", encode_i(12'hfff, 3'b011, 5'd4), 32'h1, 32'h0, pc);
        run_instr("beq equal", encode_b(13'h0010, 3'b000), 32'h55, 32'h55, pc);
        run_instr("beq", encode_b(13'h1ff0, 3'b000), 32'hffff_ffff, 32'h1, pc);
        run_instr("bne", encode_b(13'h0ffe, 3'b001), 32'hffff_ffff, 32'h1, pc);
        run_instr("blt", encode_b(13'h1000, 3'b100), 32'hffff_ffff, 32'h1, 32'h0000_0800);
        run_instr("bge", encode_b(13'h0024, 3'b101), 32'hffff_ffff, 32'h1, pc);
        run_instr("bltu", encode_b(13'h1ffe, 3'b110), 32'hffff_ffff, 32'h1, pc);
        run_instr("bgeu", encode_b(13'h0100, 3'b111), 32'hffff_ffff, 32'h1, pc);
        finish_test("compare", start);
    endtask

    task automatic test_bitmanip();
        int start;
        start = errors;
        run_instr("pack ones", encode_r(7'h04, 5'd2, 3'b100, exu_pkg::OPC_OP, 5'd1),
                  32'hffff_ffff, 32'h0000_0000, '0);
        run_instr("pack alt", encode_r(7'h04, 5'd2, 3'b100, exu_pkg::OPC_OP, 5'd2),
                  32'haaaa_aaaa, 32'h5555_5555, '0);
        run_instr("rev single", encode_r(7'h30, 5'd3, 3'b001, exu_pkg::OPC_OP_IMM, 5'd3),
                  32'h0000_0001, 32'h0, '0);
        run_instr("rev alt", encode_r(7'h30, 5'd3, 3'b001, exu_pkg::OPC_OP_IMM, 5'd4),
                  32'haaaa_aaaa, 32'h0, '0);
        run_instr("sh1add ones", encode_r(7'h10, 5'd2, 3'b010, exu_pkg::OPC_OP, 5'd5),
                  32'hffff_ffff, 32'hffff_ffff, '0);
        run_instr("sh1add top", encode_r(7'h10, 5'd2, 3'b010, exu_pkg::OPC_OP, 5'd6),
                  32'h8000_0000, 32'h0000_0001, '0);
        finish_test("bitmanip", start);
    endtask

    task automatic test_stepped();
        int start;
        start = errors;
        check_idle("stepped idle", encode_r(7'h00, 5'd2, 3'b000, exu_pkg::OPC_OP, 5'd1));
        run_instr("cpop ones", encode_r(7'h30, 5'd2, 3'b001, exu_pkg::OPC_OP_IMM, 5'd1),
                  32'hffff_ffff, 32'h0, '0);
        run_instr("ctz zero", encode_r(7'h30, 5'd1, 3'b001, exu_pkg::OPC_OP_IMM, 5'd2),
                  32'h0, 32'h0, '0);
        run_instr("ctz mid", encode_r(7'h30, 5'd1, 3'b001, exu_pkg::OPC_OP_IMM, 5'd3),
                  32'h0001_0100, 32'h0, '0);
        run_instr("ctz top", encode_r(7'h30, 5'd1, 3'b001, exu_pkg::OPC_OP_IMM, 5'd4),
                  32'h8000_0000, 32'h0, '0);
        run_instr("hmdst alt", encode_r(7'h05, 5'd2, 3'b001, exu_pkg::OPC_OP, 5'd5),
                  32'haaaa_aaaa, 32'h5555_5555, '0);
        run_instr("cpop after", encode_r(7'h30, 5'd2, 3'b001, exu_pkg::OPC_OP_IMM, 5'd6),
                  32'h0000_0001, 32'h0, '0);
        finish_test("stepped", start);
    endtask

    task automatic test_illegal();
        int start;
        start = errors;
        run_instr("bad opcode", encode_r(7'h00, 5'd2, 3'b010, 7'b0000011, 5'd1), 1, 2, '0);
        run_instr("bad funct7", encode_r(7'h01, 5'd2, 3'b000, exu_pkg::OPC_OP, 5'd2), 3, 4, '0);
        run_instr("bad unary", encode_r(7'h30, 5'd7, 3'b001, exu_pkg::OPC_OP_IMM, 5'd3),
                  5, 6, '0);
        run_instr("bad branch", encode_b(13'h0008, 3'b010), 7, 7, '0);
        check_idle("idle legal", encode_r(7'h00, 5'd2, 3'b000, exu_pkg::OPC_OP, 5'd4));
        check_idle("idle illegal", encode_r(7'h01, 5'd2, 3'b000, exu_pkg::OPC_OP, 5'd5));
        finish_test("illegal", start);
    endtask

    // Legal instruction number sel out of 27 with fields taken from r
    function automatic exu_pkg::instr_u random_instr(input int sel, input logic [31:0] r);
        logic [9:0] f;
        logic [2:0] f3;
        f  = '0;
        f3 = '0;
        if (sel < 11) begin
            case (sel)
            0:  f = 10'b0000000_000;
            1:  f = 10'b0000000_001;
            2:  f = 10'b0000000_010;
            3:  f = 10'b0000000_011;
            4:  f = 10'b0000000_100;
            5:  f = 10'b0000000_110;
            6:  f = 10'b0000000_111;
            7:  f = 10'b0100000_000;
            8:  f = 10'b0000100_100;
            9:  f = 10'b0010000_010;
            default: f = 10'b0000101_001;
            endcase
            return encode_r(f[9:3], 5'd2, f[2:0], exu_pkg::OPC_OP, r[27:23]);
        end
        if (sel == 17) return encode_r(7'h00, r[4:0], 3'b001, exu_pkg::OPC_OP_IMM, r[27:23]);
        if (sel > 17 && sel < 21) begin
            return encode_r(7'h30, 5'(sel - 17), 3'b001, exu_pkg::OPC_OP_IMM, r[27:23]);
        end
        case (sel % 6)  // Immediate ALU ops and branches share this pick
        0:       f3 = sel < 17 ? 3'b100 : 3'b111;
        1:       f3 = sel < 17 ? 3'b110 : 3'b000;
        2:       f3 = sel < 17 ? 3'b111 : 3'b001;
        3:       f3 = sel < 17 ? 3'b000 : 3'b100;
        4:       f3 = sel < 17 ? 3'b010 : 3'b101;
        default: f3 = sel < 17 ? 3'b011 : 3'b110;
        endcase
        if (sel < 17) return encode_i(r[11:0], f3, r[27:23]);
        return encode_b({r[12:1], 1'b0}, f3);
    endfunction

    task automatic test_random();
        int              start;
        int              sel;
        logic [31:0]     r;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     pc;
        exu_pkg::instr_u ins;
        start = errors;
        for (int n = 0; n < 200; n++) begin
            sel = int'($unsigned($random(seed)) % 27);
            r   = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            pc  = $random(seed);
            if (r[31]) b = a;  // Make equality branches likely
            ins = random_instr(sel, r);
            run_instr($sformatf("random %0d", n), ins, a, b, {pc[31:2], 2'b00});
        end
        finish_test("random", start);
    endtask

    initial begin
        seed         = 32'h5e17_10c4;
        errors       = 0;
        tests_failed = 0;
        tests_run    = 0;
        rstn_i       = 1'b0;
        instr_i      = '0;
        valid_i      = 1'b0;
        pc_i         = '0;
        rs1_val_i    = '0;
        rs2_val_i    = '0;
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;
        test_arith();
        test_compare();
        test_bitmanip();
        test_stepped();
        test_illegal();
        test_random();
        @(posedge clk_i);
        valid_i <= 1'b0;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/exu_pkg.sv
rtl/exu_decoder.sv
rtl/exu_alu.sv
rtl/exu_resolve.sv
rtl/exu_top.sv
tb/tb_exu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_exu -f src.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_exu > sim.log 2>&1
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1
grep -qF '*** TEST PASSED ***' sim.log || { echo "simulation ended early"; exit 1; }
exit 0
